/* include/core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

`define RESET_ADDRESS   32'h0000_0000
`define REG_COUNT       32

// ---------------------------------------------------------------------------
// Opcodes
// ---------------------------------------------------------------------------
`define OP              7'b011_0011
`define OP_IMM          7'b001_0011
`define LUI             7'b011_0111
`define AUIPC           7'b001_0111
`define JAL             7'b110_1111
`define JALR            7'b110_0111
`define BRANCH          7'b110_0011
`define STORE           7'b010_0011

// ALU funct3
`define ADD_SUB         3'b000
`define SLL             3'b001
`define SLT             3'b010
`define SLTU            3'b011
`define XOR             3'b100
`define SRL_SRA         3'b101
`define OR              3'b110
`define AND             3'b111

// Branch funct3
`define BEQ             3'b000
`define BNE             3'b001
`define BLT             3'b100
`define BGE             3'b101
`define BLTU            3'b110
`define BGEU            3'b111

// Store widths
`define SB              3'b000
`define SH              3'b001
`define SW              3'b010

// Instruction bit that selects SUB and SRA
`define FUNCT7_ALT      30

`endif

/* design/core_pkg.sv */
package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_index_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [3:0]  byte_mask_t;

    // -----------------------------------------------------------------------
    // Memory ports
    // -----------------------------------------------------------------------
    typedef struct packed {
        logic       enable;
        word_t      address;
    } fetch_request_t;

    // Address is word aligned, mask selects the written lanes
    typedef struct packed {
        logic       enable;
        word_t      address;
        byte_mask_t mask;
        word_t      data;
    } store_request_t;

    // -----------------------------------------------------------------------
    // Stage to stage bundles
    // -----------------------------------------------------------------------
    typedef struct packed {
        logic       valid;
        word_t      pc;
        opcode_t    opcode;
        funct3_t    funct3;
        logic       alt;
        word_t      immediate;
        word_t      rs1_value;
        word_t      rs2_value;
        reg_index_t write_index;
        logic       write_enable;
    } decoded_t;

    typedef struct packed {
        logic       taken;
        word_t      target;
    } redirect_t;

    typedef struct packed {
        logic       write_enable;
        reg_index_t write_index;
        word_t      result;
        logic       store_enable;
        funct3_t    store_width;
        word_t      store_address;
        word_t      store_data;
    } retire_t;

    typedef struct packed {
        logic       enable;
        reg_index_t index;
        word_t      data;
    } reg_write_t;

endpackage

/* design/fetch_unit.sv */
`include "core_macros.svh"

module fetch_unit import core_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  redirect_t      redirect,
    output fetch_request_t request,
    output logic           fetch_valid,
    output word_t          fetch_pc
);

    word_t pc;

    // Fetch runs every cycle outside reset
    assign request.enable  = !reset;
    assign request.address = pc;

    always_ff @(posedge clk)
    begin
        if (reset)
            pc <= `RESET_ADDRESS;
        else if (redirect.taken)
            pc <= redirect.target;
        else
            pc <= pc + 32'd4;
    end

    // Word returns one cycle after its address
    always_ff @(posedge clk)
    begin
        fetch_pc <= pc;
    end

    // A redirect kills the word that is still on its way
    always_ff @(posedge clk)
    begin
        if (reset || redirect.taken)
            fetch_valid <= 1'b0;
        else
            fetch_valid <= 1'b1;
    end

endmodule

/* design/instruction_decoder.sv */
`include "core_macros.svh"

module instruction_decoder import core_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  word_t      instruction,
    input  logic       fetch_valid,
    input  word_t      fetch_pc,
    input  logic       flush,
    input  reg_write_t execute_write,
    input  reg_write_t retire_write,
    output reg_index_t read_index_1,
    output reg_index_t read_index_2,
    input  word_t      read_data_1,
    input  word_t      read_data_2,
    output decoded_t   decoded
);

    opcode_t    opcode;
    funct3_t    funct3;
    reg_index_t write_index;
    word_t      immediate;
    logic       writes_register;

    // -----------------------------------------------------------------------
    // Field extraction
    // -----------------------------------------------------------------------
    assign opcode       = instruction[6:0];
    assign funct3       = instruction[14:12];
    assign write_index  = instruction[11:7];
    assign read_index_1 = instruction[19:15];
    assign read_index_2 = instruction[24:20];

    always_comb
    begin
        case (opcode)
            `STORE:
                immediate = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
            `BRANCH:
                immediate = {{20{instruction[31]}}, instruction[7], instruction[30:25],
                             instruction[11:8], 1'b0};
            `LUI, `AUIPC:
                immediate = {instruction[31:12], 12'b0};
            `JAL:
                immediate = {{12{instruction[31]}}, instruction[19:12], instruction[20],
                             instruction[30:21], 1'b0};
            default:
                immediate = {{20{instruction[31]}}, instruction[31:20]};
        endcase
    end

    always_comb
    begin
        case (opcode)
            `OP, `OP_IMM, `LUI, `AUIPC, `JAL, `JALR:
                writes_register = 1'b1;
            default:
                writes_register = 1'b0;
        endcase
    end

    // Execute first, then retire, then the register file
    function automatic word_t forward(input reg_index_t index, input word_t file_data,
                                      input reg_write_t near, input reg_write_t far);
        if (index != '0 && near.enable && near.index == index)
            return near.data;
        if (index != '0 && far.enable && far.index == index)
            return far.data;
        return file_data;
    endfunction

    // -----------------------------------------------------------------------
    // Bundle to execute
    // -----------------------------------------------------------------------
    always_comb
    begin
        decoded.valid        = fetch_valid && !flush;
        decoded.pc           = fetch_pc;
        decoded.opcode       = opcode;
        decoded.funct3       = funct3;
        // The alt bit only counts for OP and the shift-right immediates
        decoded.alt          = instruction[`FUNCT7_ALT] &&
                               (opcode == `OP || (opcode == `OP_IMM && funct3 == `SRL_SRA));
        decoded.immediate    = immediate;
        decoded.rs1_value    = forward(read_index_1, read_data_1, execute_write, retire_write);
        decoded.rs2_value    = forward(read_index_2, read_data_2, execute_write, retire_write);
        decoded.write_index  = write_index;
        decoded.write_enable = writes_register && write_index != '0;
    end

endmodule

/* design/register_file.sv */
`include "core_macros.svh"

module register_file import core_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  reg_index_t read_index_1,
    input  reg_index_t read_index_2,
    output word_t      read_data_1,
    output word_t      read_data_2,
    input  reg_write_t write
);

    word_t registers [`REG_COUNT];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `REG_COUNT; i++)
                registers[i] <= '0;
        end
        else if (write.enable && write.index != '0)
        begin
            registers[write.index] <= write.data;
        end
    end

    // x0 always reads zero
    assign read_data_1 = (read_index_1 == '0) ? '0 : registers[read_index_1];
    assign read_data_2 = (read_index_2 == '0) ? '0 : registers[read_index_2];

endmodule

/* design/execute_unit.sv */
`include "core_macros.svh"

module execute_unit import core_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  decoded_t   decoded,
    output redirect_t  redirect,
    output reg_write_t execute_write,
    output retire_t    retired
);

    decoded_t stage;
    word_t    operand_b;
    word_t    alu_out;
    word_t    pc_offset;
    word_t    base_offset;
    word_t    result;
    logic     condition;

    // Decode to execute register
    always_ff @(posedge clk)
    begin
        stage <= decoded;
        if (reset || redirect.taken)
            stage.valid <= 1'b0;
    end

    // -----------------------------------------------------------------------
    // ALU
    // -----------------------------------------------------------------------
    assign operand_b = (stage.opcode == `OP) ? stage.rs2_value : stage.immediate;

    always_comb
    begin
        case (stage.funct3)
            `ADD_SUB:
            begin
                if (stage.alt)
                    alu_out = stage.rs1_value - operand_b;
                else
                    alu_out = stage.rs1_value + operand_b;
            end
            `SLL:  alu_out = stage.rs1_value << operand_b[4:0];
            `SLT:  alu_out = {31'b0, $signed(stage.rs1_value) < $signed(operand_b)};
            `SLTU: alu_out = {31'b0, stage.rs1_value < operand_b};
            `XOR:  alu_out = stage.rs1_value ^ operand_b;
            `SRL_SRA:
            begin
                if (stage.alt)
                    alu_out = word_t'($signed(stage.rs1_value) >>> operand_b[4:0]);
                else
                    alu_out = stage.rs1_value >> operand_b[4:0];
            end
            `OR:   alu_out = stage.rs1_value | operand_b;
            `AND:  alu_out = stage.rs1_value & operand_b;
        endcase
    end

    // -----------------------------------------------------------------------
    // Branches and jumps
    // -----------------------------------------------------------------------
    always_comb
    begin
        case (stage.funct3)
            `BEQ:    condition = stage.rs1_value == stage.rs2_value;
            `BNE:    condition = stage.rs1_value != stage.rs2_value;
            `BLT:    condition = $signed(stage.rs1_value) < $signed(stage.rs2_value);
            `BGE:    condition = $signed(stage.rs1_value) >= $signed(stage.rs2_value);
            `BLTU:   condition = stage.rs1_value < stage.rs2_value;
            `BGEU:   condition = stage.rs1_value >= stage.rs2_value;
            default: condition = 1'b0;
        endcase
    end

    // pc + imm serves AUIPC, JAL and branches; rs1 + imm serves JALR and stores
    assign pc_offset   = stage.pc + stage.immediate;
    assign base_offset = stage.rs1_value + stage.immediate;

    assign redirect.taken  = stage.valid &&
                             (stage.opcode == `JAL || stage.opcode == `JALR ||
                              (stage.opcode == `BRANCH && condition));
    assign redirect.target = (stage.opcode == `JALR) ? {base_offset[31:1], 1'b0} : pc_offset;

    always_comb
    begin
        case (stage.opcode)
            `LUI:        result = stage.immediate;
            `AUIPC:      result = pc_offset;
            `JAL, `JALR: result = stage.pc + 32'd4;
            default:     result = alu_out;
        endcase
    end

    // -----------------------------------------------------------------------
    // Outputs
    // -----------------------------------------------------------------------
    assign execute_write.enable = stage.valid && stage.write_enable;
    assign execute_write.index  = stage.write_index;
    assign execute_write.data   = result;

    assign retired.write_enable  = execute_write.enable;
    assign retired.write_index   = stage.write_index;
    assign retired.result        = result;
    assign retired.store_enable  = stage.valid && stage.opcode == `STORE;
    assign retired.store_width   = stage.funct3;
    assign retired.store_address = base_offset;
    assign retired.store_data    = stage.rs2_value;

endmodule

/* design/retire_unit.sv */
`include "core_macros.svh"

module retire_unit import core_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  retire_t        retired,
    output reg_write_t     reg_write,
    output store_request_t data_request
);

    retire_t    stage;
    logic [1:0] lane;

    always_ff @(posedge clk)
    begin
        stage <= retired;
        if (reset)
        begin
            stage.write_enable <= 1'b0;
            stage.store_enable <= 1'b0;
        end
    end

    assign reg_write.enable = stage.write_enable;
    assign reg_write.index  = stage.write_index;
    assign reg_write.data   = stage.result;

    // -----------------------------------------------------------------------
    // Store lane formatting
    // -----------------------------------------------------------------------
    assign lane = stage.store_address[1:0];

    assign data_request.enable  = stage.store_enable;
    assign data_request.address = {stage.store_address[31:2], 2'b00};
    assign data_request.data    = stage.store_data << {lane, 3'b000};

    always_comb
    begin
        case (stage.store_width)
            `SB:     data_request.mask = 4'b0001 << lane;
            `SH:     data_request.mask = 4'b0011 << lane;
            default: data_request.mask = 4'b1111;
        endcase
    end

endmodule

/* design/rv_core.sv */
module rv_core import core_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    output fetch_request_t instruction_request,
    input  word_t          instruction_data,
    output store_request_t data_request
);

    redirect_t  redirect;
    logic       fetch_valid;
    word_t      fetch_pc;
    decoded_t   decoded;
    reg_write_t execute_write;
    reg_write_t retire_write;
    retire_t    retired;
    reg_index_t read_index_1;
    reg_index_t read_index_2;
    word_t      read_data_1;
    word_t      read_data_2;

    fetch_unit fetch_unit_i
    (
        .clk(clk),
        .reset(reset),
        .redirect(redirect),
        .request(instruction_request),
        .fetch_valid(fetch_valid),
        .fetch_pc(fetch_pc)
    );

    instruction_decoder instruction_decoder_i
    (
        .clk(clk),
        .reset(reset),
        .instruction(instruction_data),
        .fetch_valid(fetch_valid),
        .fetch_pc(fetch_pc),
        .flush(redirect.taken),
        .execute_write(execute_write),
        .retire_write(retire_write),
        .read_index_1(read_index_1),
        .read_index_2(read_index_2),
        .read_data_1(read_data_1),
        .read_data_2(read_data_2),
        .decoded(decoded)
    );

    register_file register_file_i
    (
        .clk(clk),
        .reset(reset),
        .read_index_1(read_index_1),
        .read_index_2(read_index_2),
        .read_data_1(read_data_1),
        .read_data_2(read_data_2),
        .write(retire_write)
    );

    execute_unit execute_unit_i
    (
        .clk(clk),
        .reset(reset),
        .decoded(decoded),
        .redirect(redirect),
        .execute_write(execute_write),
        .retired(retired)
    );

    retire_unit retire_unit_i
    (
        .clk(clk),
        .reset(reset),
        .retired(retired),
        .reg_write(retire_write),
        .data_request(data_request)
    );

endmodule

/* verification/tb_rv_core.sv */
`include "core_macros.svh"

module tb_rv_core import core_pkg::*;
;

    localparam int PROGRAM_SLOTS = 200;
    // Last five slots hold the fixed tail and the final self loop
    localparam int BODY_SLOTS    = PROGRAM_SLOTS - 5;
    localparam int STORE_TIMEOUT = 5000;
    localparam int QUIET_CYCLES  = 50;
    localparam opcode_t UNDEFINED_OPCODE = 7'b000_1011;

    typedef struct packed {
        opcode_t    opcode;
        funct3_t    funct3;
        logic       alt;
        reg_index_t rd;
        reg_index_t rs1;
        reg_index_t rs2;
        word_t      imm;
    } slot_t;

    logic           clk = 1'b0;
    logic           reset;
    fetch_request_t instruction_request;
    word_t          instruction_data;
    store_request_t data_request;

    slot_t          program_slots [PROGRAM_SLOTS];
    word_t          program_mem [PROGRAM_SLOTS];
    logic           landing [PROGRAM_SLOTS];
    word_t          model_regs [32];
    store_request_t expected_stores [$];
    word_t          lcg_state;
    int             fill_index;
    int             store_count;
    logic           first_fetch_seen;

    rv_core rv_core_i
    (
        .clk(clk),
        .reset(reset),
        .instruction_request(instruction_request),
        .instruction_data(instruction_data),
        .data_request(data_request)
    );

    initial
    begin
        forever #4 clk = ~clk;
    end

    // ---------------------------------------------------------------------------
    // Reporting
    // ---------------------------------------------------------------------------
    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        if (actual !== expected)
            fail_run($sformatf("CHECK FAILED at time %0t: %s is %h, expected %h",
                               $time, name, actual, expected));
    endtask

    // ---------------------------------------------------------------------------
    // Random program
    // ---------------------------------------------------------------------------
    function automatic word_t next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Upper LCG bits have the longest period
    function automatic int random_below(input int limit);
        word_t value;
        value = next_random();
        return int'(value[31:16]) % limit;
    endfunction

    // Small register pool so neighbours often depend on each other
    function automatic reg_index_t random_reg();
        return reg_index_t'(random_below(8));
    endfunction

    function automatic word_t assemble(input slot_t s);
        word_t w;
        case (s.opcode)
            `OP:
                w = {1'b0, s.alt, 5'b0, s.rs2, s.rs1, s.funct3, s.rd, s.opcode};
            `OP_IMM, `JALR:
                w = {s.imm[11:0], s.rs1, s.funct3, s.rd, s.opcode};
            `STORE:
                w = {s.imm[11:5], s.rs2, s.rs1, s.funct3, s.imm[4:0], s.opcode};
            `BRANCH:
                w = {s.imm[12], s.imm[10:5], s.rs2, s.rs1, s.funct3, s.imm[4:1], s.imm[11],
                     s.opcode};
            `LUI, `AUIPC:
                w = {s.imm[31:12], s.rd, s.opcode};
            `JAL:
                w = {s.imm[20], s.imm[10:1], s.imm[11], s.imm[19:12], s.rd, s.opcode};
            default:
                w = {s.imm[24:0], s.opcode};
        endcase
        return w;
    endfunction

    task automatic place_instruction(input slot_t s);
        program_slots[fill_index] = s;
        program_mem[fill_index]   = assemble(s);
        fill_index++;
    endtask

    task automatic generate_program();
        slot_t      s;
        word_t      value;
        int         choice;
        int         skip;
        reg_index_t link;
        for (int i = 0; i < PROGRAM_SLOTS; i++)
            landing[i] = 1'b0;
        while (fill_index < BODY_SLOTS)
        begin
            s      = '0;
            s.rd   = random_reg();
            s.rs1  = random_reg();
            s.rs2  = random_reg();
            value  = next_random();
            choice = random_below(16);
            // Jumps skip one or two slots
            skip   = 2 + random_below(2);
            if (choice == 12 && fill_index + skip <= BODY_SLOTS)
            begin
                s.opcode = `BRANCH;
                choice   = random_below(6);
                s.funct3 = funct3_t'(choice < 2 ? choice : choice + 2);
                s.imm    = word_t'(skip * 4);
                landing[fill_index + skip] = 1'b1;
            end
            else if (choice == 13 && fill_index + skip <= BODY_SLOTS)
            begin
                s.opcode = `JAL;
                s.imm    = word_t'(skip * 4);
                landing[fill_index + skip] = 1'b1;
            end
            else if (choice == 14 && fill_index + 1 + skip <= BODY_SLOTS &&
                     !landing[fill_index + 1])
            begin
                // AUIPC and JALR pair that no jump enters half way
                s.opcode = `AUIPC;
                s.rd     = reg_index_t'(1 + random_below(7));
                s.imm    = '0;
                link     = s.rd;
                place_instruction(s);
                s        = '0;
                s.opcode = `JALR;
                s.rd     = random_reg();
                s.rs1    = link;
                s.imm    = word_t'((skip + 1) * 4);
                landing[fill_index + skip] = 1'b1;
            end
            else if (choice == 9 || choice == 10)
            begin
                s.opcode = (choice == 9) ? `LUI : `AUIPC;
                s.imm    = {value[31:12], 12'b0};
            end
            else if (choice == 11 || choice == 15)
            begin
                s.opcode = `STORE;
                s.rs1    = '0;
                s.funct3 = funct3_t'(random_below(3));
                s.imm    = 32'h0000_0100 +
                           {24'b0, value[7:0] & ((s.funct3 == `SB) ? 8'hff :
                                                 (s.funct3 == `SH) ? 8'hfe : 8'hfc)};
            end
            else if (choice < 5)
            begin
                s.opcode = `OP;
                s.funct3 = funct3_t'(random_below(8));
                s.alt    = (s.funct3 == `ADD_SUB || s.funct3 == `SRL_SRA) &&
                           random_below(2) == 1;
            end
            else
            begin
                s.opcode = `OP_IMM;
                s.funct3 = funct3_t'(random_below(8));
                if (s.funct3 == `SLL)
                    s.imm = {27'b0, value[4:0]};
                else if (s.funct3 == `SRL_SRA)
                begin
                    s.alt = value[5];
                    s.imm = {21'b0, value[5], 5'b0, value[4:0]};
                end
                else
                    s.imm = {{20{value[11]}}, value[11:0]};
            end
            place_instruction(s);
        end

        // Fixed tail of an undefined opcode, a write to x0, two stores and a self loop
        value    = next_random();
        s        = '0;
        s.opcode = UNDEFINED_OPCODE;
        // Its rd field names x6, so a stray write shows in the last store
        s.imm    = {value[31:5], 5'd6};
        place_instruction(s);
        s        = '0;
        s.opcode = `OP_IMM;
        s.rs1    = 5'd5;
        s.imm    = 32'd123;
        place_instruction(s);
        s        = '0;
        s.opcode = `STORE;
        s.funct3 = `SW;
        s.imm    = 32'h0000_0200;
        place_instruction(s);
        s        = '0;
        s.opcode = `STORE;
        s.funct3 = `SW;
        s.rs2    = 5'd6;
        s.imm    = 32'h0000_0204;
        place_instruction(s);
        s        = '0;
        s.opcode = `JAL;
        place_instruction(s);
    endtask

    // ---------------------------------------------------------------------------
    // Instruction set model
    // ---------------------------------------------------------------------------
    function automatic word_t alu_model(input funct3_t funct3, input logic alt,
                                        input word_t a, input word_t b);
        case (funct3)
            `ADD_SUB: return alt ? a - b : a + b;
            `SLL:     return a << b[4:0];
            `SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            `SLTU:    return (a < b) ? 32'd1 : 32'd0;
            `XOR:     return a ^ b;
            `SRL_SRA: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            `OR:      return a | b;
            default:  return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input funct3_t funct3, input word_t a, input word_t b);
        case (funct3)
            `BEQ:    return a == b;
            `BNE:    return a != b;
            `BLT:    return $signed(a) < $signed(b);
            `BGE:    return $signed(a) >= $signed(b);
            `BLTU:   return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic write_reg(input reg_index_t index, input word_t value);
        if (index != '0)
            model_regs[index] = value;
    endtask

    task automatic run_model();
        slot_t          s;
        word_t          pc;
        word_t          next_pc;
        word_t          a;
        word_t          b;
        word_t          address;
        store_request_t store;
        logic           done;
        int             steps;
        for (int r = 0; r < 32; r++)
            model_regs[r] = '0;
        pc    = `RESET_ADDRESS;
        done  = 1'b0;
        steps = 0;
        while (!done)
        begin
            s       = program_slots[int'(pc >> 2)];
            a       = model_regs[s.rs1];
            b       = model_regs[s.rs2];
            next_pc = pc + 32'd4;
            case (s.opcode)
                `OP:     write_reg(s.rd, alu_model(s.funct3, s.alt, a, b));
                `OP_IMM: write_reg(s.rd, alu_model(s.funct3, s.alt, a, s.imm));
                `LUI:    write_reg(s.rd, s.imm);
                `AUIPC:  write_reg(s.rd, pc + s.imm);
                `JAL:
                begin
                    next_pc = pc + s.imm;
                    write_reg(s.rd, pc + 32'd4);
                end
                `JALR:
                begin
                    next_pc = (a + s.imm) & ~32'd1;
                    write_reg(s.rd, pc + 32'd4);
                end
                `BRANCH:
                begin
                    if (branch_taken(s.funct3, a, b))
                        next_pc = pc + s.imm;
                end
                `STORE:
                begin
                    address       = a + s.imm;
                    store.enable  = 1'b1;
                    store.address = {address[31:2], 2'b00};
                    case (s.funct3)
                        `SB:     store.mask = 4'b0001 << address[1:0];
                        `SH:     store.mask = 4'b0011 << address[1:0];
                        default: store.mask = 4'b1111;
                    endcase
                    store.data = b << (8 * address[1:0]);
                    expected_stores.push_back(store);
                end
                default: ;
            endcase
            done = (next_pc == pc);
            pc   = next_pc;
            steps++;
            if (steps > PROGRAM_SLOTS * 4)
                fail_run("Model never reached the final self loop");
        end
    endtask

    // ---------------------------------------------------------------------------
    // Memory models and store checker
    // ---------------------------------------------------------------------------
    function automatic word_t fetch_word(input word_t address);
        int index;
        index = int'(address >> 2);
        if (index >= 0 && index < PROGRAM_SLOTS)
            return program_mem[index];
        else
            return {address[24:0] ^ address[31:7], 7'b000_0000};
    endfunction

    // One cycle read latency
    always @(posedge clk)
    begin
        if (instruction_request.enable)
            instruction_data <= fetch_word(instruction_request.address);
    end

    always @(negedge clk)
    begin
        store_request_t expected;
        if (reset)
        begin
            check_value("instruction_request.enable", {31'b0, instruction_request.enable}, '0);
            check_value("data_request.enable", {31'b0, data_request.enable}, '0);
        end
        else
        begin
            if (!first_fetch_seen && instruction_request.enable)
            begin
                check_value("instruction_request.address", instruction_request.address,
                            `RESET_ADDRESS);
                first_fetch_seen = 1'b1;
            end
            if (data_request.enable && store_count >= expected_stores.size())
            begin
                fail_run($sformatf("Unexpected extra store to address %h at time %0t",
                                   data_request.address, $time));
            end
            else if (data_request.enable)
            begin
                expected = expected_stores[store_count];
                check_value("data_request.address", data_request.address, expected.address);
                check_value("data_request.mask", {28'b0, data_request.mask},
                            {28'b0, expected.mask});
                check_value("data_request.data", data_request.data, expected.data);
                store_count++;
            end
        end
    end

    // ---------------------------------------------------------------------------
    // Main sequence
    // ---------------------------------------------------------------------------
    initial
    begin
        int wait_cycles;
        reset            = 1'b1;
        instruction_data = '0;
        lcg_state        = 32'hc1da7cbc;
        fill_index       = 0;
        store_count      = 0;
        first_fetch_seen = 1'b0;
        generate_program();
        run_model();
        $display("Program of %0d instructions, %0d stores expected",
                 PROGRAM_SLOTS, expected_stores.size());

        repeat (8) @(posedge clk);
        reset <= 1'b0;

        wait_cycles = 0;
        while (store_count < expected_stores.size())
        begin
            @(posedge clk);
            wait_cycles++;
            if (wait_cycles > STORE_TIMEOUT)
                fail_run($sformatf("Timeout after %0d cycles with %0d of %0d stores seen",
                                   wait_cycles, store_count, expected_stores.size()));
        end

        // Core now spins on the self loop and must not store
        wait_cycles = 0;
        while (wait_cycles < QUIET_CYCLES)
        begin
            @(posedge clk);
            wait_cycles++;
        end

        if (store_count == expected_stores.size() && first_fetch_seen)
        begin
            $display("Simulation finished: PASS");
            $finish;
        end
        else
            fail_run("Store count or first fetch wrong at the end of the run");
    end

endmodule

/* list.f */
+incdir+include
design/core_pkg.sv
design/fetch_unit.sv
design/instruction_decoder.sv
design/register_file.sv
design/execute_unit.sv
design/retire_unit.sv
design/rv_core.sv
verification/tb_rv_core.sv

/* Makefile */
# Verilator build and run for the rv_core testbench

VERILATOR       ?= verilator
TOP             ?= tb_rv_core
FILE_LIST       ?= list.f
BUILD_DIR       ?= obj_dir
LOG             ?= sim.log
VERILATOR_FLAGS ?= --binary --timing -j 0
PASS_TEXT       ?= Simulation finished: PASS

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
HEADERS := $(wildcard include/*.svh)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILE_LIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: compile
	./$(BINARY) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Test failed, see $(LOG)"; exit 1)
	@echo "Test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
